/* include/tlp_switch_defines.svh */
// stream widths, queue count, queue depth and counter width for the TLP switch
`ifndef TLP_SWITCH_DEFINES_SVH
`define TLP_SWITCH_DEFINES_SVH

// stream data width, same as the core's 16-bit TLP bus
`define TLP_DATA_W 16
// number of store-and-forward queues
`define TLP_NUM_Q 4
// width of the core's BAR hit vector
`define TLP_BAR_W 7
// queue depth in beats, power of two
`define TLP_Q_DEPTH 32
// longest TLP admitted, in beats
`define TLP_MAX_BEATS 8
// width of the TLP counters
`define TLP_CNT_W 16

// derived widths
`define TLP_QIDX_W ($clog2(`TLP_NUM_Q))
`define TLP_FREE_W ($clog2(`TLP_Q_DEPTH + 1))

`endif

/* verilog/tlp_switch_pkg.sv */
// package with the TLP stream beat types
`include "tlp_switch_defines.svh"

package tlp_switch_pkg;

	// one beat of a TLP stream
	typedef struct packed {
		logic valid;
		logic sop;
		logic eop;
		logic [`TLP_DATA_W-1:0] data;
	} tlp_beat_t;

	// receive beat from the core, bar_hit only meaningful with sop
	typedef struct packed {
		tlp_beat_t beat;
		logic [`TLP_BAR_W-1:0] bar_hit;
	} rx_beat_t;

endpackage

/* verilog/rx_dispatch.sv */
// module rx_dispatch: BAR hit routing, queue admission, rx and drop counters
`include "tlp_switch_defines.svh"

module rx_dispatch (
	input  logic                       clk_125,
	input  logic                       rstn,
	input  tlp_switch_pkg::rx_beat_t   rx_i,
	input  logic [`TLP_FREE_W-1:0]     free_i [`TLP_NUM_Q],
	output tlp_switch_pkg::tlp_beat_t  wr_beat_o [`TLP_NUM_Q],
	output logic [`TLP_CNT_W-1:0]      rx_cnt_o,
	output logic [`TLP_CNT_W-1:0]      drop_cnt_o
);
	import tlp_switch_pkg::*;

	localparam int QW = `TLP_QIDX_W;
	localparam int FW = `TLP_FREE_W;

	tlp_beat_t beat;
	logic [`TLP_NUM_Q-1:0] q_hits;
	logic [QW-1:0] sop_q;
	logic sop_admit;
	logic in_pkt;
	logic cur_admit;
	logic [QW-1:0] cur_q;
	logic [QW-1:0] wr_q;
	logic wr_en;
	logic [`TLP_NUM_Q-1:0] wr_vld;
	logic wr_sop;
	logic wr_eop;
	logic [`TLP_DATA_W-1:0] wr_data;

	assign beat = rx_i.beat;
	assign q_hits = rx_i.bar_hit[`TLP_NUM_Q-1:0];

	// lowest hit bar wins
	always_comb begin
		sop_q = '0;
		for (int i = `TLP_NUM_Q - 1; i >= 0; i--) begin
			if (q_hits[i])
				sop_q = QW'(i);
		end
	end

	// a beat still in the write register is not yet counted by the queue
	assign sop_admit = (|q_hits) &&
		(free_i[sop_q] >= FW'(`TLP_MAX_BEATS) + FW'(wr_vld[sop_q]));

	assign wr_en = beat.valid && (beat.sop ? sop_admit : (in_pkt && cur_admit));
	assign wr_q = beat.sop ? sop_q : cur_q;

	// decision taken at sop, held until eop
	always_ff @(posedge clk_125 or negedge rstn) begin
		if (!rstn) begin
			in_pkt <= 1'b0;
			cur_admit <= 1'b0;
			cur_q <= '0;
			rx_cnt_o <= '0;
			drop_cnt_o <= '0;
		end else if (beat.valid) begin
			if (beat.sop) begin
				cur_q <= sop_q;
				cur_admit <= sop_admit;
				rx_cnt_o <= rx_cnt_o + 1'b1;
				if (!sop_admit)
					drop_cnt_o <= drop_cnt_o + 1'b1;
			end
			in_pkt <= !beat.eop;
		end
	end

	// write strobe per queue
	always_ff @(posedge clk_125 or negedge rstn) begin
		if (!rstn)
			wr_vld <= '0;
		else
			wr_vld <= wr_en ? (`TLP_NUM_Q'(1) << wr_q) : '0;
	end

	// beat payload, shared by all queues
	always_ff @(posedge clk_125) begin
		wr_sop <= beat.sop;
		wr_eop <= beat.eop;
		wr_data <= beat.data;
	end

	always_comb begin
		for (int i = 0; i < `TLP_NUM_Q; i++) begin
			wr_beat_o[i].valid = wr_vld[i];
			wr_beat_o[i].sop = wr_sop;
			wr_beat_o[i].eop = wr_eop;
			wr_beat_o[i].data = wr_data;
		end
	end

	// body beats only between a sop and its eop
	a_rx_in_pkt : assert property (@(posedge clk_125) disable iff (!rstn)
		beat.valid && !beat.sop |-> in_pkt)
		else $error("rx beat without sop outside a TLP");

endmodule

/* verilog/tlp_queue.sv */
// module tlp_queue: store-and-forward TLP buffer with complete packet count
`include "tlp_switch_defines.svh"

module tlp_queue (
	input  logic                       clk_125,
	input  logic                       rstn,
	input  tlp_switch_pkg::tlp_beat_t  wr_beat_i,
	input  logic                       rd_en_i,
	output tlp_switch_pkg::tlp_beat_t  head_o,
	output logic                       pkt_avail_o,
	output logic [`TLP_FREE_W-1:0]     free_o
);
	import tlp_switch_pkg::*;

	localparam int AW = $clog2(`TLP_Q_DEPTH);
	localparam int FW = `TLP_FREE_W;

	// sop, eop and data of each stored beat
	logic [`TLP_DATA_W+1:0] mem [`TLP_Q_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [FW-1:0] occ;
	logic [FW-1:0] pkt_cnt;
	logic wr_en;
	logic wr_eop;
	logic rd_eop;

	assign wr_en = wr_beat_i.valid;
	assign wr_eop = wr_en && wr_beat_i.eop;
	assign rd_eop = rd_en_i && head_o.eop;

	always_ff @(posedge clk_125) begin
		if (wr_en)
			mem[wr_ptr] <= {wr_beat_i.sop, wr_beat_i.eop, wr_beat_i.data};
	end

	always_ff @(posedge clk_125 or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			occ <= '0;
			pkt_cnt <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en_i)
				rd_ptr <= rd_ptr + 1'b1;
			occ <= occ + FW'(wr_en) - FW'(rd_en_i);
			// whole packets, counted on eop in and eop out
			pkt_cnt <= pkt_cnt + FW'(wr_eop) - FW'(rd_eop);
		end
	end

	// head beat, valid while anything is stored
	always_comb begin
		head_o.valid = (occ != '0);
		{head_o.sop, head_o.eop, head_o.data} = mem[rd_ptr];
	end

	assign pkt_avail_o = (pkt_cnt != '0);
	assign free_o = FW'(`TLP_Q_DEPTH) - occ;

	// the dispatcher admits only what fits
	a_no_wr_full : assert property (@(posedge clk_125) disable iff (!rstn)
		wr_en |-> occ != FW'(`TLP_Q_DEPTH))
		else $error("queue write while full");

	// the arbiter pops only stored beats
	a_no_rd_empty : assert property (@(posedge clk_125) disable iff (!rstn)
		rd_en_i |-> occ != '0)
		else $error("queue pop while empty");

endmodule

/* verilog/tx_arbiter.sv */
// module tx_arbiter: round-robin queue selection, core tx handshake, tx counter
`include "tlp_switch_defines.svh"

module tx_arbiter (
	input  logic                       clk_125,
	input  logic                       rstn,
	input  logic [`TLP_NUM_Q-1:0]      pkt_avail_i,
	input  tlp_switch_pkg::tlp_beat_t  head_i [`TLP_NUM_Q],
	output logic [`TLP_NUM_Q-1:0]      rd_en_o,
	output logic                       tx_req_o,
	input  logic                       tx_rdy_i,
	output tlp_switch_pkg::tlp_beat_t  tx_o,
	output logic [`TLP_CNT_W-1:0]      tx_cnt_o
);
	import tlp_switch_pkg::*;

	localparam int QW = `TLP_QIDX_W;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_SEND
	} state_t;

	state_t state;
	// last granted queue, search starts one above it
	logic [QW-1:0] grant_q;
	logic [QW-1:0] sel_q;
	logic sel_found;
	logic pop;
	tlp_beat_t head;
	logic tx_vld;
	logic tx_sop;
	logic tx_eop;
	logic [`TLP_DATA_W-1:0] tx_data;

	// round-robin search over queues holding a whole TLP
	always_comb begin
		int idx;
		sel_found = 1'b0;
		sel_q = grant_q;
		for (int k = 1; k <= `TLP_NUM_Q; k++) begin
			idx = (int'(grant_q) + k) % `TLP_NUM_Q;
			if (!sel_found && pkt_avail_i[idx]) begin
				sel_found = 1'b1;
				sel_q = QW'(idx);
			end
		end
	end

	assign head = head_i[grant_q];

	// first pop on the granted ready, then one per cycle until eop
	assign pop = (state == ST_REQ && tx_rdy_i) || (state == ST_SEND);
	assign rd_en_o = pop ? (`TLP_NUM_Q'(1) << grant_q) : '0;

	always_ff @(posedge clk_125 or negedge rstn) begin
		if (!rstn) begin
			state <= ST_IDLE;
			grant_q <= QW'(`TLP_NUM_Q - 1);
			tx_req_o <= 1'b0;
			tx_vld <= 1'b0;
			tx_sop <= 1'b0;
			tx_eop <= 1'b0;
			tx_cnt_o <= '0;
		end else begin
			tx_vld <= pop;
			tx_sop <= pop && head.sop;
			tx_eop <= pop && head.eop;
			if (tx_o.valid && tx_o.sop)
				tx_cnt_o <= tx_cnt_o + 1'b1;
			case (state)
				ST_IDLE: begin
					if (sel_found) begin
						grant_q <= sel_q;
						tx_req_o <= 1'b1;
						state <= ST_REQ;
					end
				end
				ST_REQ: begin
					if (tx_rdy_i) begin
						tx_req_o <= 1'b0;
						// single beat TLP ends right here
						state <= head.eop ? ST_IDLE : ST_SEND;
					end
				end
				ST_SEND: begin
					if (head.eop)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_125) begin
		if (pop)
			tx_data <= head.data;
	end

	always_comb begin
		tx_o.valid = tx_vld;
		tx_o.sop = tx_sop;
		tx_o.eop = tx_eop;
		tx_o.data = tx_data;
	end

	// request and packet beats never overlap on the core port
	a_no_req_in_send : assert property (@(posedge clk_125) disable iff (!rstn)
		tx_o.valid |-> !tx_req_o)
		else $error("tx_req_o high while a TLP is being sent");

	// each non-sop beat directly follows a non-eop beat, so no gap before eop
	a_tx_no_gap : assert property (@(posedge clk_125) disable iff (!rstn)
		tx_o.valid && !tx_o.sop |-> $past(tx_o.valid && !tx_o.eop))
		else $error("tx beat without a preceding sop or with a gap");

endmodule

/* verilog/tlp_switch.sv */
// module tlp_switch: dispatcher, TLP queues and transmit arbiter
`include "tlp_switch_defines.svh"

module tlp_switch (
	input  logic                       clk_125,
	input  logic                       rstn,
	input  tlp_switch_pkg::rx_beat_t   rx_i,
	output tlp_switch_pkg::tlp_beat_t  tx_o,
	output logic                       tx_req_o,
	input  logic                       tx_rdy_i,
	output logic [`TLP_CNT_W-1:0]      rx_cnt_o,
	output logic [`TLP_CNT_W-1:0]      tx_cnt_o,
	output logic [`TLP_CNT_W-1:0]      drop_cnt_o
);
	import tlp_switch_pkg::*;

	tlp_beat_t wr_beat [`TLP_NUM_Q];
	tlp_beat_t head [`TLP_NUM_Q];
	logic [`TLP_FREE_W-1:0] q_free [`TLP_NUM_Q];
	logic [`TLP_NUM_Q-1:0] pkt_avail;
	logic [`TLP_NUM_Q-1:0] rd_en;

	rx_dispatch u_rx_dispatch (
		.clk_125    (clk_125),
		.rstn       (rstn),
		.rx_i       (rx_i),
		.free_i     (q_free),
		.wr_beat_o  (wr_beat),
		.rx_cnt_o   (rx_cnt_o),
		.drop_cnt_o (drop_cnt_o)
	);

	// one queue per routable BAR
	for (genvar g = 0; g < `TLP_NUM_Q; g++) begin : g_queue
		tlp_queue u_tlp_queue (
			.clk_125     (clk_125),
			.rstn        (rstn),
			.wr_beat_i   (wr_beat[g]),
			.rd_en_i     (rd_en[g]),
			.head_o      (head[g]),
			.pkt_avail_o (pkt_avail[g]),
			.free_o      (q_free[g])
		);
	end

	tx_arbiter u_tx_arbiter (
		.clk_125     (clk_125),
		.rstn        (rstn),
		.pkt_avail_i (pkt_avail),
		.head_i      (head),
		.rd_en_o     (rd_en),
		.tx_req_o    (tx_req_o),
		.tx_rdy_i    (tx_rdy_i),
		.tx_o        (tx_o),
		.tx_cnt_o    (tx_cnt_o)
	);

endmodule

/* verification/clk_rst_gen.sv */
// module clk_rst_gen: testbench clock and active low reset
module clk_rst_gen #(
	parameter int PERIOD_NS = 4,
	parameter int RESET_CYCLES = 16
) (
	output logic clk_o,
	output logic rstn_o
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
	end

	// reset released on a rising edge after the hold time
	initial begin
		rstn_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		rstn_o <= 1'b1;
	end

endmodule

/* verification/tlp_switch_checker.sv */
// module tlp_switch_checker: expected TLP store, tx stream and counter checks
`include "tlp_switch_defines.svh"

module tlp_switch_checker (
	input  logic                       clk_125,
	input  logic                       rstn,
	input  tlp_switch_pkg::tlp_beat_t  tx_o,
	input  logic                       tx_req_o,
	input  logic                       tx_rdy_i,
	input  logic [`TLP_CNT_W-1:0]      rx_cnt_o,
	input  logic [`TLP_CNT_W-1:0]      tx_cnt_o,
	input  logic [`TLP_CNT_W-1:0]      drop_cnt_o
);
	timeunit 1ns;
	timeprecision 100ps;
	import tlp_switch_pkg::*;

	localparam int NQ = `TLP_NUM_Q;
	localparam int EXP_DEPTH = 1024;

	// expected beats per queue, eop above data
	logic [`TLP_DATA_W:0] exp_mem [NQ][EXP_DEPTH];
	int push_idx [NQ] = '{default: 0};
	int pop_idx [NQ] = '{default: 0};
	int pushed_pkts [NQ] = '{default: 0};
	int popped_pkts [NQ] = '{default: 0};
	int data_errs = 0;
	int proto_errs = 0;
	bit rr_check = 1'b0;
	bit rr_started;
	int last_q;
	int cur_q;
	bit in_pkt;
	bit skip_pkt;
	bit grant_seen;

	task automatic push_beat(input int q, input logic eop, input logic [`TLP_DATA_W-1:0] d);
		exp_mem[q][push_idx[q] % EXP_DEPTH] = {eop, d};
		push_idx[q]++;
	endtask

	task automatic push_pkt(input int q);
		pushed_pkts[q]++;
	endtask

	task automatic report_value(input string name, input longint exp_v, input longint act_v);
		$display("ERR %0t %s exp %0h act %0h", $time, name, exp_v, act_v);
		data_errs++;
	endtask

	task automatic check_reset();
		if (tx_req_o !== 1'b0)
			report_value("tx_req_o", 0, tx_req_o);
		if (tx_o.valid !== 1'b0)
			report_value("tx_o.valid", 0, tx_o.valid);
		if (rx_cnt_o !== '0)
			report_value("rx_cnt_o", 0, rx_cnt_o);
		if (tx_cnt_o !== '0)
			report_value("tx_cnt_o", 0, tx_cnt_o);
		if (drop_cnt_o !== '0)
			report_value("drop_cnt_o", 0, drop_cnt_o);
	endtask

	task automatic check_counts(input int exp_rx, input int exp_tx, input int exp_drop);
		if (rx_cnt_o !== `TLP_CNT_W'(exp_rx))
			report_value("rx_cnt_o", exp_rx, rx_cnt_o);
		if (tx_cnt_o !== `TLP_CNT_W'(exp_tx))
			report_value("tx_cnt_o", exp_tx, tx_cnt_o);
		if (drop_cnt_o !== `TLP_CNT_W'(exp_drop))
			report_value("drop_cnt_o", exp_drop, drop_cnt_o);
	endtask

	always @(posedge clk_125 or negedge rstn) begin
		int exp_q;
		logic [`TLP_DATA_W:0] exp_beat;
		if (!rstn) begin
			last_q = NQ - 1;
			in_pkt = 1'b0;
			skip_pkt = 1'b0;
			grant_seen = 1'b0;
			rr_started = 1'b0;
		end else begin
			if (!rr_check)
				rr_started = 1'b0;
			if (grant_seen && !(tx_o.valid && tx_o.sop)) begin
				$display("protocol error at %0t: granted request not followed by a sop",
					$time);
				proto_errs++;
			end
			if (tx_o.valid) begin
				if (tx_o.sop) begin
					if (in_pkt) begin
						$display("protocol error at %0t: sop inside a TLP on tx_o", $time);
						proto_errs++;
					end
					if (!grant_seen) begin
						$display("protocol error at %0t: TLP sent without a granted request",
							$time);
						proto_errs++;
					end
					// queue tag sits in the low bits of the first beat
					cur_q = int'(tx_o.data[1:0]);
					skip_pkt = (pushed_pkts[cur_q] - popped_pkts[cur_q]) <= 0;
					if (skip_pkt) begin
						$display("protocol error at %0t: TLP for queue %0d sent, none expected",
							$time, cur_q);
						proto_errs++;
					end else begin
						// loaded queues take turns from queue 0 upward
						if (rr_check) begin
							exp_q = rr_started ? (last_q + 1) % NQ : 0;
							if (exp_q != cur_q)
								report_value("tx_o.data[1:0]", exp_q, cur_q);
						end
						rr_started = rr_check;
						popped_pkts[cur_q] <= popped_pkts[cur_q] + 1;
					end
					last_q = cur_q;
					in_pkt = 1'b1;
				end else if (!in_pkt) begin
					$display("protocol error at %0t: tx beat outside a TLP", $time);
					proto_errs++;
				end
				if (in_pkt && !skip_pkt) begin
					exp_beat = exp_mem[cur_q][pop_idx[cur_q] % EXP_DEPTH];
					pop_idx[cur_q]++;
					if (tx_o.data !== exp_beat[`TLP_DATA_W-1:0])
						report_value("tx_o.data", exp_beat[`TLP_DATA_W-1:0], tx_o.data);
					if (tx_o.eop !== exp_beat[`TLP_DATA_W])
						report_value("tx_o.eop", exp_beat[`TLP_DATA_W], tx_o.eop);
				end
				if (tx_o.eop)
					in_pkt = 1'b0;
			end else if (in_pkt) begin
				$display("protocol error at %0t: gap inside a TLP on tx_o", $time);
				proto_errs++;
				in_pkt = 1'b0;
			end
			grant_seen = tx_req_o && tx_rdy_i;
		end
	end

endmodule

/* verification/tlp_switch_tb.sv */
// module tlp_switch_tb: stimulus, LFSR, admission reference model and watchdog
`include "tlp_switch_defines.svh"

module tlp_switch_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import tlp_switch_pkg::*;

	localparam int NQ = `TLP_NUM_Q;
	localparam logic [31:0] SEED = 32'h06a32b3f;
	localparam int N_ROUTE = 40;
	localparam int N_UNR = 10;
	localparam int N_BP = 24;
	localparam int N_RR = 3;
	localparam int MAX_BEATS_ALL = (N_ROUTE + N_UNR + N_BP + NQ * N_RR) * `TLP_MAX_BEATS;
	// 20 cycles of 4 ns per stimulus beat, plus margin
	localparam int TIMEOUT_NS = MAX_BEATS_ALL * 20 * 4 + 4000;

	logic clk_125;
	logic rstn;
	rx_beat_t rx_i;
	tlp_beat_t tx_o;
	logic tx_req_o;
	logic tx_rdy_i;
	logic [`TLP_CNT_W-1:0] rx_cnt_o;
	logic [`TLP_CNT_W-1:0] tx_cnt_o;
	logic [`TLP_CNT_W-1:0] drop_cnt_o;

	logic [31:0] lfsr;
	int occ [NQ];
	int exp_rx;
	int exp_tx;
	int exp_drop;
	int seq;

	clk_rst_gen #(.PERIOD_NS(4), .RESET_CYCLES(16)) u_clk_rst_gen (
		.clk_o  (clk_125),
		.rstn_o (rstn)
	);

	tlp_switch dut (
		.clk_125    (clk_125),
		.rstn       (rstn),
		.rx_i       (rx_i),
		.tx_o       (tx_o),
		.tx_req_o   (tx_req_o),
		.tx_rdy_i   (tx_rdy_i),
		.rx_cnt_o   (rx_cnt_o),
		.tx_cnt_o   (tx_cnt_o),
		.drop_cnt_o (drop_cnt_o)
	);

	tlp_switch_checker chk (
		.clk_125    (clk_125),
		.rstn       (rstn),
		.tx_o       (tx_o),
		.tx_req_o   (tx_req_o),
		.tx_rdy_i   (tx_rdy_i),
		.rx_cnt_o   (rx_cnt_o),
		.tx_cnt_o   (tx_cnt_o),
		.drop_cnt_o (drop_cnt_o)
	);

	// fibonacci LFSR, taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	// routing and admission model, returns the queue or -1 on drop
	function automatic int ref_route(input logic [`TLP_BAR_W-1:0] bar_hit, input int len);
		int q;
		q = -1;
		for (int i = NQ - 1; i >= 0; i--) begin
			if (bar_hit[i])
				q = i;
		end
		exp_rx++;
		if (q >= 0 && (`TLP_Q_DEPTH - occ[q]) < `TLP_MAX_BEATS)
			q = -1;
		if (q < 0) begin
			exp_drop++;
		end else begin
			occ[q] += len;
			exp_tx++;
		end
		return q;
	endfunction

	// random bar hit whose lowest routable bit is q
	function automatic logic [`TLP_BAR_W-1:0] bar_for_q(input int q);
		logic [`TLP_BAR_W-1:0] r;
		logic [`TLP_BAR_W-1:0] low;
		r = `TLP_BAR_W'(rand_bits(`TLP_BAR_W));
		low = (`TLP_BAR_W'(1) << q) - 1'b1;
		return (r & ~low) | (`TLP_BAR_W'(1) << q);
	endfunction

	function automatic int pending_total();
		int n;
		n = 0;
		for (int i = 0; i < NQ; i++)
			n += chk.pushed_pkts[i] - chk.popped_pkts[i];
		return n;
	endfunction

	task automatic send_tlp(input logic [`TLP_BAR_W-1:0] bar_hit, input int tag);
		int len;
		int q;
		logic [`TLP_DATA_W-1:0] dat [`TLP_MAX_BEATS];
		rx_beat_t b;
		len = int'(rand_bits(3)) + 1;
		q = ref_route(bar_hit, len);
		seq++;
		for (int i = 0; i < len; i++) begin
			dat[i] = (i == 0) ? {seq[13:0], 2'(tag)} : `TLP_DATA_W'(rand_bits(`TLP_DATA_W));
			if (q >= 0)
				chk.push_beat(q, i == len - 1, dat[i]);
		end
		if (q >= 0)
			chk.push_pkt(q);
		for (int i = 0; i < len; i++) begin
			b = '0;
			b.beat.valid = 1'b1;
			b.beat.sop = (i == 0);
			b.beat.eop = (i == len - 1);
			b.beat.data = dat[i];
			b.bar_hit = bar_hit;
			@(posedge clk_125);
			rx_i <= b;
		end
		@(posedge clk_125);
		rx_i <= '0;
	endtask

	// all expected TLPs sent, queues empty again
	task automatic wait_drain();
		while (pending_total() != 0)
			@(posedge clk_125);
		repeat (`TLP_MAX_BEATS + 4) @(posedge clk_125);
		for (int i = 0; i < NQ; i++)
			occ[i] = 0;
	endtask

	initial begin
		int q;
		lfsr = SEED;
		rx_i = '0;
		tx_rdy_i = 1'b0;
		exp_rx = 0;
		exp_tx = 0;
		exp_drop = 0;
		seq = 0;
		for (int i = 0; i < NQ; i++)
			occ[i] = 0;
		wait (rstn === 1'b1);
		@(negedge clk_125);
		chk.check_reset();

		// routing with the core always ready
		@(posedge clk_125);
		tx_rdy_i <= 1'b1;
		repeat (N_ROUTE) begin
			q = int'(rand_bits(2));
			send_tlp(bar_for_q(q), q);
			wait_drain();
		end

		// no routable BAR bit
		repeat (N_UNR) begin
			send_tlp({3'(rand_bits(3)), 4'b0000}, int'(rand_bits(2)));
			wait_drain();
		end

		// back-pressure, queues fill and drop
		@(posedge clk_125);
		tx_rdy_i <= 1'b0;
		repeat (N_BP) begin
			q = int'(rand_bits(2));
			send_tlp(bar_for_q(q), q);
		end
		repeat (4) @(posedge clk_125);
		while (pending_total() != 0) begin
			@(posedge clk_125);
			tx_rdy_i <= 1'(rand_bits(1));
		end
		wait_drain();

		// round robin across loaded queues
		@(posedge clk_125);
		tx_rdy_i <= 1'b0;
		chk.rr_check = 1'b1;
		for (int i = 0; i < NQ; i++) begin
			repeat (N_RR) send_tlp(bar_for_q(i), i);
		end
		repeat (4) @(posedge clk_125);
		tx_rdy_i <= 1'b1;
		wait_drain();
		chk.rr_check = 1'b0;

		repeat (8) @(posedge clk_125);
		@(negedge clk_125);
		chk.check_counts(exp_rx, exp_tx, exp_drop);
		$display("errors: data %0d protocol %0d", chk.data_errs, chk.proto_errs);
		if (chk.data_errs + chk.proto_errs == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the run did not finish in %0d ns", TIMEOUT_NS);
		$display("errors: data %0d protocol %0d", chk.data_errs, chk.proto_errs);
		$display("tests failed");
		$finish;
	end

endmodule

/* tlp_switch.f */
+incdir+include
verilog/tlp_switch_pkg.sv
verilog/rx_dispatch.sv
verilog/tlp_queue.sv
verilog/tx_arbiter.sv
verilog/tlp_switch.sv
verification/clk_rst_gen.sv
verification/tlp_switch_checker.sv
verification/tlp_switch_tb.sv

/* Bender.yml */
package:
  name: tlp_switch

sources:
  - include_dirs:
      - include
    files:
      - verilog/tlp_switch_pkg.sv
      - verilog/rx_dispatch.sv
      - verilog/tlp_queue.sv
      - verilog/tx_arbiter.sv
      - verilog/tlp_switch.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/clk_rst_gen.sv
      - verification/tlp_switch_checker.sv
      - verification/tlp_switch_tb.sv
